//--- Bender.yml
package:
  name: lsu

sources:
  - src/lsu_pkg.sv
  - src/lsu_store_align.sv
  - src/lsu_load_align.sv
  - src/lsu_ctrl.sv
  - src/lsu_top.sv
  - target: test
    files:
      - tb/lsu_mem_model.sv
      - tb/lsu_tb.sv

//--- sources.f
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_load_align.sv
src/lsu_ctrl.sv
src/lsu_top.sv
tb/lsu_mem_model.sv
tb/lsu_tb.sv

//--- src/lsu_ctrl.sv
// one access in flight at most; EX must hold its request steady while grant is low
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        data_req_ex_i,      // EX wants a memory access
  input  logic        ex_valid_i,         // EX stage advances this cycle
  input  lsu_ex_req_t ex_req_i,
  input  logic        gnt_i,
  input  logic        rvalid_i,
  input  logic        err_i,              // only meaningful with grant
  output logic        data_req_o,
  output logic        misaligned_1st_o,   // current access needs a second part
  output logic        data_misaligned_o,  // registered version for the controller
  output logic        lsu_ready_ex_o,
  output logic        lsu_ready_wb_o,
  output logic        load_err_o,
  output logic        store_err_o,
  output logic        busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RVALID,           // access in flight, WB waits on it
    WAIT_RVALID_EX_STALL,  // access in flight while EX is stalled
    IDLE_EX_STALL          // data returned, EX still stalled
  } lsu_state_e;

  lsu_state_e state_q, state_d;
  offset_t    offset;

  assign offset = ex_req_i.addr[OFFSET_W-1:0];

  //////////////////// misalignment
  // a word off the boundary or a half word at the last byte spills into the next word
  always_comb
  begin
    misaligned_1st_o = 1'b0;
    if (data_req_ex_i && !ex_req_i.misaligned_2nd)
    begin
      case (ex_req_i.dtype)
        DT_WORD: misaligned_1st_o = (offset != 2'd0);
        DT_HALF: misaligned_1st_o = (offset == 2'd3);
        default: misaligned_1st_o = 1'b0;  // bytes always fit
      endcase
    end
  end

  //////////////////// request FSM
  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        if (data_req_ex_i)
        begin
          data_req_o     = 1'b1;
          lsu_ready_ex_o = gnt_i;  // EX held until accepted
          if (gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        lsu_ready_wb_o = rvalid_i;
        if (rvalid_i)
        begin
          // next request may go out together with this rvalid
          if (data_req_ex_i)
          begin
            data_req_o     = 1'b1;
            lsu_ready_ex_o = gnt_i;
            if (gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;
          end
          else
            state_d = IDLE;
        end
      end

      WAIT_RVALID_EX_STALL:
      begin
        // no new request while EX is stuck on the old one
        if (rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q           <= IDLE;
      data_misaligned_o <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (ex_valid_i)
        data_misaligned_o <= misaligned_1st_o;  // seen once EX moves on
    end
  end

  assign load_err_o  = gnt_i & err_i & ~ex_req_i.we;
  assign store_err_o = gnt_i & err_i & ex_req_i.we;
  assign busy_o      = (state_q != IDLE) | data_req_o;

  //////////////////// bus checks
  // memory must answer the old access before granting a new one
  a_gnt_needs_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == WAIT_RVALID && gnt_i) |-> rvalid_i)
    else $error("grant before rvalid of the outstanding access");

  // nothing outstanding in IDLE
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == IDLE) |-> !rvalid_i)
    else $error("rvalid without an outstanding access");

  a_err_with_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    err_i |-> gnt_i)
    else $error("error raised without grant");

  a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown(ex_req_i.addr))
    else $error("unknown address on a request");

endmodule

//--- src/lsu_load_align.sv
// expects the two parts of a split load back to back; result is valid only in the rvalid cycle
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  lsu_ex_req_t ex_req_i,          // access currently in EX
  input  logic        gnt_i,             // memory accepted the request
  input  logic        rvalid_i,          // read data valid this cycle
  input  word_t       rdata_i,           // raw word from memory
  input  logic        misaligned_1st_i,  // current access needs a second part
  output word_t       rdata_o            // aligned and extended result
);

  // attributes of the access in flight, taken at grant
  data_type_t dtype_q;
  offset_t    offset_q;
  logic       sign_ext_q;
  logic       we_q;

  word_t      rdata_q;    // raw first half or last result
  word_t      word_ext;   // word, possibly joined from two halves
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;
  word_t      rdata_ext;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dtype_q    <= DT_WORD;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (gnt_i)  // request leaves, its response comes later
    begin
      dtype_q    <= ex_req_i.dtype;
      offset_q   <= ex_req_i.addr[OFFSET_W-1:0];
      sign_ext_q <= ex_req_i.sign_ext;
      we_q       <= ex_req_i.we;
    end
  end

  //////////////////// alignment
  // at a high offset the low bytes come from the held first half
  always_comb
  begin
    case (offset_q)
      2'd0:    word_ext = rdata_i;
      2'd1:    word_ext = {rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    word_ext = {rdata_i[15:0], rdata_q[31:16]};
      default: word_ext = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (offset_q)
      2'd0:    half_sel = rdata_i[15:0];
      2'd1:    half_sel = rdata_i[23:8];
      2'd2:    half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[31:24]};  // split half word
    endcase
  end

  always_comb
  begin
    case (offset_q)
      2'd0:    byte_sel = rdata_i[7:0];
      2'd1:    byte_sel = rdata_i[15:8];
      2'd2:    byte_sel = rdata_i[23:16];
      default: byte_sel = rdata_i[31:24];
    endcase
  end

  //////////////////// extension
  always_comb
  begin
    case (dtype_q)
      DT_WORD: rdata_ext = word_ext;
      DT_HALF: rdata_ext = {{16{sign_ext_q & half_sel[15]}}, half_sel};
      default: rdata_ext = {{24{sign_ext_q & byte_sel[7]}}, byte_sel};
    endcase
  end

  // keep the raw word while a split access is under way, else the final value
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (rvalid_i && !we_q)
    begin
      if (ex_req_i.misaligned_2nd || misaligned_1st_i)
        rdata_q <= rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;  // bypass in the rvalid cycle

endmodule

//--- src/lsu_pkg.sv
// 32-bit bus only; size code 3 behaves as a byte, and misaligned accesses take two bus cycles
package lsu_pkg;

  //////////////////// widths
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;
  localparam int WORD_BYTES = 4;                      // byte lanes per bus word
  localparam int OFFSET_W   = $clog2(WORD_BYTES);     // byte offset within a word

  typedef logic [DATA_W-1:0]     word_t;       // bus word or register file value
  typedef logic [ADDR_W-1:0]     addr_t;       // byte address
  typedef logic [WORD_BYTES-1:0] be_t;         // one enable per byte lane
  typedef logic [OFFSET_W-1:0]   offset_t;     // low address bits
  typedef logic [1:0]            data_type_t;  // access size code

  //////////////////// access size codes
  localparam data_type_t DT_WORD = 2'd0;
  localparam data_type_t DT_HALF = 2'd1;
  localparam data_type_t DT_BYTE = 2'd2;  // 2'd3 decodes the same way

  //////////////////// structs
  // one access as presented by the execute stage
  typedef struct packed {
    logic       we;              // store when set
    data_type_t dtype;
    logic       sign_ext;        // sign-extend loaded half word / byte
    logic       misaligned_2nd;  // second part of a split access
    addr_t      addr;
    word_t      wdata;           // unrotated store data
  } lsu_ex_req_t;

  // request fields towards data memory
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    word_t wdata;  // already rotated to its byte lanes
  } mem_req_t;

endpackage

//--- src/lsu_store_align.sv
// purely combinational; the address offset alone decides the write data rotation
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*;
(
  input  lsu_ex_req_t ex_req_i,  // access from the execute stage
  output mem_req_t    mem_o      // request fields to data memory
);

  offset_t offset;  // byte position inside the word
  be_t     be;
  word_t   wdata_rot;

  assign offset = ex_req_i.addr[OFFSET_W-1:0];

  //////////////////// byte enables
  always_comb
  begin
    case (ex_req_i.dtype)
      DT_WORD:
      begin
        if (!ex_req_i.misaligned_2nd)
        begin
          case (offset)  // upper lanes from the offset on
            2'd0:    be = 4'b1111;
            2'd1:    be = 4'b1110;
            2'd2:    be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end
        else
        begin
          case (offset)  // remaining low lanes of the next word
            2'd0:    be = 4'b0000;  // never split, kept for completeness
            2'd1:    be = 4'b0001;
            2'd2:    be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
      DT_HALF:
      begin
        if (!ex_req_i.misaligned_2nd)
        begin
          case (offset)
            2'd0:    be = 4'b0011;
            2'd1:    be = 4'b0110;
            2'd2:    be = 4'b1100;
            default: be = 4'b1000;  // low byte only, high byte goes in part two
          endcase
        end
        else
          be = 4'b0001;  // high byte of a half word split at offset 3
      end
      default: be = be_t'(1) << offset;  // byte, codes 2 and 3
    endcase
  end

  //////////////////// write data
  // rotate left by the offset so each byte sits in the lane its address picks.
  // the second part reuses the same rotation, the wrapped bytes fall into the low lanes
  always_comb
  begin
    case (offset)
      2'd0:    wdata_rot = ex_req_i.wdata;
      2'd1:    wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  assign mem_o.addr  = ex_req_i.addr;  // full byte address, memory ignores low bits
  assign mem_o.we    = ex_req_i.we;
  assign mem_o.be    = be;
  assign mem_o.wdata = wdata_rot;

endmodule

//--- src/lsu_top.sv
// single master, single memory port; req/gnt/rvalid with at most one access outstanding
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // execute stage side
  input  logic        data_req_ex_i,
  input  logic        ex_valid_i,
  input  lsu_ex_req_t ex_req_i,
  output word_t       data_rdata_ex_o,    // to register file
  output logic        data_misaligned_o,  // second part required
  output logic        lsu_ready_ex_o,
  output logic        lsu_ready_wb_o,
  output logic        load_err_o,
  output logic        store_err_o,
  output logic        busy_o,

  // data memory side
  output logic        data_req_o,
  output mem_req_t    mem_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic        data_err_i,
  input  word_t       data_rdata_i
);

  logic misaligned_1st;  // ctrl tells the load path a split is pending

  //////////////////// control
  lsu_ctrl u_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .data_req_ex_i     (data_req_ex_i),
    .ex_valid_i        (ex_valid_i),
    .ex_req_i          (ex_req_i),
    .gnt_i             (data_gnt_i),
    .rvalid_i          (data_rvalid_i),
    .err_i             (data_err_i),
    .data_req_o        (data_req_o),
    .misaligned_1st_o  (misaligned_1st),
    .data_misaligned_o (data_misaligned_o),
    .lsu_ready_ex_o    (lsu_ready_ex_o),
    .lsu_ready_wb_o    (lsu_ready_wb_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  //////////////////// data paths
  lsu_store_align u_store_align (
    .ex_req_i (ex_req_i),
    .mem_o    (mem_o)
  );

  lsu_load_align u_load_align (
    .clk              (clk),
    .rst_n            (rst_n),
    .ex_req_i         (ex_req_i),
    .gnt_i            (data_gnt_i),
    .rvalid_i         (data_rvalid_i),
    .rdata_i          (data_rdata_i),
    .misaligned_1st_i (misaligned_1st),
    .rdata_o          (data_rdata_ex_o)
  );

endmodule

//--- tb/lsu_mem_model.sv
// data memory responder: 256 bytes, grant after 0 to 3 idle cycles, rvalid 1 to 3 cycles later
`timescale 1ns/1ps

module lsu_mem_model import lsu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_i,
  input  mem_req_t mem_i,
  input  logic     err_en_i,  // allow random errors on grant
  output logic     gnt_o,
  output logic     rvalid_o,
  output logic     err_o,
  output word_t    rdata_o
);

  logic [7:0] mem [256];  // filled by the testbench at time zero
  int         seed;
  int         writes;     // store parts actually written
  int         lat;
  mem_req_t   req_q;
  logic [7:0] base;

  initial
  begin
    seed     = 32'h2023;
    writes   = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    err_o    = 1'b0;
    rdata_o  = '0;
    wait (rst_n);
    forever
    begin
      @(negedge clk);  // request level is stable mid cycle
      if (req_i)
      begin
        repeat ($unsigned($random(seed)) % 4) @(posedge clk);
        @(posedge clk);
        #2;
        gnt_o = 1'b1;
        err_o = err_en_i && ($unsigned($random(seed)) % 4 == 0);
        @(negedge clk);
        req_q = mem_i;  // held steady by EX until this grant
        base  = {req_q.addr[7:2], 2'b00};
        if (req_q.we && !err_o)
        begin
          for (int i = 0; i < WORD_BYTES; i++)
            if (req_q.be[i])
              mem[base + 8'(i)] = req_q.wdata[8*i +: 8];
          writes++;
        end
        lat = 1 + $unsigned($random(seed)) % 3;
        @(posedge clk);
        #2;
        gnt_o = 1'b0;
        err_o = 1'b0;
        for (int i = 1; i < lat; i++)
        begin
          @(posedge clk);
          #2;
        end
        rvalid_o = 1'b1;
        rdata_o  = {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
        @(posedge clk);
        #2;
        rvalid_o = 1'b0;
      end
    end
  end

endmodule

//--- tb/lsu_tb.sv
// plays the execute stage with seeded random accesses; memory region is 256 bytes and wraps
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*;
();

  localparam int MAX_CYCLES = 20000;  // about 300 accesses at 12 cycles each, plus margin

  logic        clk;
  logic        rst_n;
  logic        data_req_ex;
  logic        ex_valid;
  lsu_ex_req_t ex_req;
  word_t       data_rdata_ex;
  logic        data_misaligned, lsu_ready_ex, lsu_ready_wb;
  logic        load_err, store_err, busy, data_req;
  mem_req_t    mem_o;
  logic        data_gnt, data_rvalid, data_err, err_en;
  word_t       data_rdata;

  logic [7:0]  ref_mem [256];  // reference copy of the memory contents
  int          seed;
  int          errors, checks, cycles, exp_writes, errs_at_start;

  lsu_top DUT (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (data_req_ex), .ex_valid_i (ex_valid), .ex_req_i (ex_req),
    .data_rdata_ex_o (data_rdata_ex), .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o (lsu_ready_ex), .lsu_ready_wb_o (lsu_ready_wb),
    .load_err_o (load_err), .store_err_o (store_err), .busy_o (busy),
    .data_req_o (data_req), .mem_o (mem_o), .data_gnt_i (data_gnt),
    .data_rvalid_i (data_rvalid), .data_err_i (data_err), .data_rdata_i (data_rdata)
  );

  lsu_mem_model u_mem (
    .clk (clk), .rst_n (rst_n), .req_i (data_req), .mem_i (mem_o), .err_en_i (err_en),
    .gnt_o (data_gnt), .rvalid_o (data_rvalid), .err_o (data_err), .rdata_o (data_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("run stopped after %0d cycles, an access never completed", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic compare(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // error flags follow grant and error in the same cycle, never otherwise
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      compare("load_err_o", load_err, data_gnt & data_err & ~ex_req.we);
      compare("store_err_o", store_err, data_gnt & data_err & ex_req.we);
    end
  end

  // bytes a..a+n-1 from the reference, little endian, then extended
  function automatic word_t expected_load(input data_type_t dt, input logic sx,
                                          input logic [7:0] a);
    word_t v;
    int    n;
    n = (dt == DT_WORD) ? 4 : (dt == DT_HALF) ? 2 : 1;
    v = '0;
    for (int k = 0; k < n; k++)
      v[8*k +: 8] = ref_mem[8'(a + k)];
    if (sx && n == 2)
      v = {{16{v[15]}}, v[15:0]};
    if (sx && n == 1)
      v = {{24{v[7]}}, v[7:0]};
    return v;
  endfunction

  task automatic wait_grant(input bit check_bp, output bit err_seen);
    mem_req_t first;
    bit       first_set;
    first_set = 1'b0;
    do
    begin
      @(negedge clk);
      if (check_bp)  // request must stay put until accepted
      begin
        if (!first_set)
        begin
          first     = mem_o;
          first_set = 1'b1;
        end
        compare("data_req_o", data_req, 1'b1);
        compare("lsu_ready_ex_o", lsu_ready_ex, data_gnt);
        compare("mem_o.addr", mem_o.addr, first.addr);
        compare("mem_o.wdata", mem_o.wdata, first.wdata);
        compare("mem_o.we/be", {mem_o.we, mem_o.be}, {first.we, first.be});
      end
    end
    while (!data_gnt);
    err_seen = data_err;
  endtask

  task automatic run_access(input bit we, input data_type_t dt, input bit sx,
                            input logic [7:0] a, input word_t wd);
    bit          mis;
    bit [1:0]    perr;
    bit          e;
    int          parts, n;
    word_t       got;
    lsu_ex_req_t r;
    mis   = (dt == DT_WORD && a[1:0] != 2'd0) || (dt == DT_HALF && a[1:0] == 2'd3);
    parts = mis ? 2 : 1;
    n     = (dt == DT_WORD) ? 4 : (dt == DT_HALF) ? 2 : 1;
    perr  = '0;
    for (int p = 0; p < parts; p++)
    begin
      @(posedge clk);
      #2;
      r.we             = we;
      r.dtype          = dt;
      r.sign_ext       = sx;
      r.misaligned_2nd = (p == 1);
      r.addr           = 32'(a) + 32'(4 * p);  // same offset, next word
      r.wdata          = wd;
      ex_req           = r;
      data_req_ex      = 1'b1;
      if (p == 1)
      begin
        @(negedge clk);
        compare("data_misaligned_o", data_misaligned, 1'b1);
      end
      wait_grant(p == 0, e);
      perr[p] = e;
      if (we && !e)
        exp_writes++;
    end
    @(posedge clk);
    #2;
    data_req_ex = 1'b0;
    @(negedge clk);
    compare("data_misaligned_o", data_misaligned, 1'b0);  // last part never splits
    while (!data_rvalid)
    begin
      compare("lsu_ready_wb_o", lsu_ready_wb, 1'b0);  // WB waits on the data
      @(negedge clk);
    end
    compare("lsu_ready_wb_o", lsu_ready_wb, 1'b1);
    got = data_rdata_ex;
    if (we)
    begin
      for (int k = 0; k < n; k++)
        if (!perr[(int'(a[1:0]) + k) / 4])
          ref_mem[8'(a + k)] = wd[8*k +: 8];
    end
    else if (perr == 2'b00)
      compare("data_rdata_ex_o", got, expected_load(dt, sx, a));
  endtask

  task automatic random_access();
    word_t r;
    r = $random(seed);
    run_access(r[0], data_type_t'(r[2:1]), r[3], r[15:8], $random(seed));
  endtask

  // load with EX frozen over grant and rvalid
  task automatic run_stalled_load(input logic [7:0] a);
    bit    e;
    word_t got;
    got = '0;
    @(posedge clk);
    #2;
    ex_valid    = 1'b0;
    ex_req      = '{we: 1'b0, dtype: DT_WORD, sign_ext: 1'b0, misaligned_2nd: 1'b0,
                    addr: 32'({a[7:2], 2'b00}), wdata: '0};
    data_req_ex = 1'b1;
    wait_grant(1'b1, e);
    repeat (6)
    begin
      @(negedge clk);
      compare("data_req_o stalled", data_req, 1'b0);
      compare("busy_o stalled", busy, 1'b1);
      if (data_rvalid)
        got = data_rdata_ex;
    end
    compare("data_rdata_ex_o held", data_rdata_ex, got);
    compare("data_rdata_ex_o", got, expected_load(DT_WORD, 1'b0, {a[7:2], 2'b00}));
    @(posedge clk);
    #2;
    data_req_ex = 1'b0;
    ex_valid    = 1'b1;
  endtask

  task automatic finish_test(input string name);
    $display("%s finished with %0d errors", name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  initial
  begin
    word_t      r;
    data_type_t dt;
    logic [7:0] a;
    seed          = 32'h2023;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    exp_writes    = 0;
    errs_at_start = 0;
    rst_n         = 1'b0;
    data_req_ex   = 1'b0;
    ex_valid      = 1'b1;
    ex_req        = '0;
    err_en        = 1'b0;
    for (int i = 0; i < 256; i++)
    begin
      ref_mem[i]   = 8'(i * 29 + 7) ^ 8'(i >> 3);  // every address bit matters
      u_mem.mem[i] = ref_mem[i];
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    //////////////////// aligned stores
    repeat (40)
    begin
      r  = $random(seed);
      dt = data_type_t'(r[1:0]);
      a  = r[15:8];
      if (dt == DT_WORD)
        a[1:0] = 2'b00;
      if (dt == DT_HALF)
        a[0] = 1'b0;
      run_access(1'b1, dt, 1'b0, a, $random(seed));
    end
    for (int w = 0; w < 64; w++)
      run_access(1'b0, DT_WORD, 1'b0, 8'(4 * w), '0);  // full readback
    finish_test("aligned stores");

    //////////////////// sub-word loads
    repeat (60)
    begin
      r  = $random(seed);
      dt = (r[1:0] == 2'd0) ? DT_HALF : data_type_t'(r[1:0]);
      a  = r[15:8];
      if (dt == DT_HALF)
        a[0] = 1'b0;
      run_access(1'b0, dt, r[2], a, '0);
    end
    finish_test("extended loads");

    //////////////////// split accesses
    repeat (40)
    begin
      r  = $random(seed);
      dt = r[0] ? DT_WORD : DT_HALF;
      a  = r[15:8];
      if (dt == DT_HALF)
        a[1:0] = 2'd3;
      else if (a[1:0] == 2'd0)
        a[1:0] = 2'd1;
      run_access(r[1], dt, r[2], a, $random(seed));
    end
    finish_test("misaligned");

    repeat (40) random_access();
    compare("memory write count", u_mem.writes, exp_writes);
    finish_test("grant backpressure");

    repeat (5) run_stalled_load(8'($random(seed)));
    finish_test("ex stall");

    err_en = 1'b1;
    repeat (40) random_access();
    err_en = 1'b0;
    compare("memory write count", u_mem.writes, exp_writes);
    finish_test("bus errors");

    $display("6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
